/* rtl/pdp1d_pkg.sv */
package pdp1d_pkg;

  ///////////////////////////////
  // sizes
  ///////////////////////////////

  // lanes per beat
  localparam int LANES      = 4;
  // 8-bit element plus 3 bits of growth
  localparam int LANE_W     = 11;
  // one line buffer per channel position
  localparam int BUF_DEPTH  = 8;
  localparam int POS_W      = 3;
  // window-size count, wraps at 8
  localparam int SIZE_W     = 3;
  // register stages between input and write-back
  localparam int PIPE_DEPTH = 4;

  ///////////////////////////////
  // types
  ///////////////////////////////

  typedef logic signed [LANE_W-1:0] lane_t;
  typedef lane_t [LANES-1:0] lane_vec_t;

  // code 3 is not used, combine gives zero
  typedef enum logic [1:0] {
    POOL_MEAN = 2'd0,
    POOL_MAX  = 2'd1,
    POOL_MIN  = 2'd2
  } pool_type_e;

  // input word
  typedef struct packed {
    logic [POS_W-1:0] cpos;
    lane_vec_t        data;
  } pdp_din_t;

  // beat in flight through the delay pipe
  typedef struct packed {
    lane_vec_t         data;
    logic [POS_W-1:0]  cpos;
    logic              first;
    logic              last;
    logic              lc;
    logic              load;
    logic [SIZE_W-1:0] size;
  } pool_item_t;

  // output word
  typedef struct packed {
    logic              lc;
    logic [SIZE_W-1:0] size;
    lane_vec_t         data;
  } pool_out_t;

  ///////////////////////////////
  // lane combine
  ///////////////////////////////

  // acc is the buffer entry, din the new beat
  function automatic lane_vec_t pool_combine(input lane_vec_t  acc,
                                             input lane_vec_t  din,
                                             input pool_type_e ptype);
    lane_vec_t res;
    lane_t     a;
    lane_t     b;
    res = '0;
    for (int i = 0; i < LANES; i++) begin
      a = acc[i];
      b = din[i];
      case (ptype)
        // sum wraps at lane width
        POOL_MEAN: res[i] = a + b;
        POOL_MAX:  res[i] = (a > b) ? a : b;
        POOL_MIN:  res[i] = (a < b) ? a : b;
        default:   res[i] = '0;
      endcase
    end
    return res;
  endfunction

endpackage

/* rtl/pdp1d_in_stage.sv */
`timescale 1ns/1ns

module pdp1d_in_stage (
  input  logic                  nvdla_core_clk,
  input  logic                  nvdla_core_rstn,
  input  logic                  din_vld,
  input  pdp1d_pkg::pdp_din_t   din,
  input  logic                  din_1st,
  input  logic                  din_last,
  input  logic                  din_lc,
  input  logic                  datin_disable,
  input  logic                  unit_en,
  input  logic                  item_in_rdy,
  output logic                  din_rdy,
  output logic                  item_in_vld,
  output pdp1d_pkg::pool_item_t item_in
);
  import pdp1d_pkg::*;

  logic              load;
  logic              din_acc;
  logic [SIZE_W-1:0] size_cnt;

  ///////////////////////////////
  // handshake
  ///////////////////////////////

  // straight through, the pipe head decides
  assign din_rdy     = item_in_rdy;
  assign item_in_vld = din_vld;
  assign din_acc     = din_vld & din_rdy;

  // beat takes part in pooling
  assign load = ~datin_disable & unit_en;

  ///////////////////////////////
  // window-size counter
  ///////////////////////////////

  // counts loaded line-end beats of the window
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      size_cnt <= '0;
    end else if (din_acc & load & din_lc) begin
      // window closes, restart
      if (din_last) begin
        size_cnt <= '0;
      end else begin
        size_cnt <= size_cnt + 1'b1;
      end
    end
  end

  ///////////////////////////////
  // item packing
  ///////////////////////////////

  assign item_in.data  = din.data;
  assign item_in.cpos  = din.cpos;
  assign item_in.first = din_1st;
  assign item_in.last  = din_last;
  assign item_in.lc    = din_lc;
  assign item_in.load  = load;
  // count before this beat's update
  assign item_in.size  = size_cnt;

  // an offered item waits unchanged until the pipe takes it
  a_item_held : assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    item_in_vld && !item_in_rdy |=> item_in_vld && $stable(item_in)
  );

endmodule

/* rtl/pdp1d_delay_pipe.sv */
`timescale 1ns/1ns

module pdp1d_delay_pipe #(
  parameter type payload_t = logic
) (
  input  logic     nvdla_core_clk,
  input  logic     nvdla_core_rstn,
  input  logic     in_vld,
  input  payload_t in_pd,
  input  logic     out_rdy,
  output logic     in_rdy,
  output logic     out_vld,
  output payload_t out_pd
);
  import pdp1d_pkg::*;

  logic [PIPE_DEPTH-1:0] vld_q;
  logic [PIPE_DEPTH-1:0] stg_rdy;
  payload_t              pd_q [PIPE_DEPTH];

  ///////////////////////////////
  // ready chain
  ///////////////////////////////

  // last stage sees the consumer
  assign stg_rdy[PIPE_DEPTH-1] = ~vld_q[PIPE_DEPTH-1] | out_rdy;

  // stage takes data when empty or when it drains
  for (genvar i = 0; i < PIPE_DEPTH - 1; i++) begin : g_rdy
    assign stg_rdy[i] = ~vld_q[i] | stg_rdy[i+1];
  end

  ///////////////////////////////
  // stage registers
  ///////////////////////////////

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      vld_q <= '0;
    end else begin
      if (stg_rdy[0]) begin
        vld_q[0] <= in_vld;
      end
      for (int i = 1; i < PIPE_DEPTH; i++) begin
        if (stg_rdy[i]) begin
          vld_q[i] <= vld_q[i-1];
        end
      end
    end
  end

  // payload only moves with its valid
  always_ff @(posedge nvdla_core_clk) begin
    if (in_vld & stg_rdy[0]) begin
      pd_q[0] <= in_pd;
    end
    for (int i = 1; i < PIPE_DEPTH; i++) begin
      if (vld_q[i-1] & stg_rdy[i]) begin
        pd_q[i] <= pd_q[i-1];
      end
    end
  end

  assign in_rdy  = stg_rdy[0];
  assign out_vld = vld_q[PIPE_DEPTH-1];
  assign out_pd  = pd_q[PIPE_DEPTH-1];

  // a stalled output beat stays put
  a_out_stable : assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    out_vld && !out_rdy |=> out_vld && $stable(out_pd)
  );

endmodule

/* rtl/pdp1d_accum_buf.sv */
`timescale 1ns/1ns

module pdp1d_accum_buf (
  input  logic                          nvdla_core_clk,
  input  logic                          nvdla_core_rstn,
  input  pdp1d_pkg::pool_type_e         pool_type,
  input  logic                          commit,
  input  pdp1d_pkg::pool_item_t         item,
  input  logic [pdp1d_pkg::POS_W-1:0]   rd_idx,
  output pdp1d_pkg::lane_vec_t          wr_data,
  output pdp1d_pkg::lane_vec_t          rd_data
);
  import pdp1d_pkg::*;

  lane_vec_t line_buf [BUF_DEPTH];
  lane_vec_t old_data;
  lane_vec_t pooled;
  logic      wr_en;

  ///////////////////////////////
  // combine at write-back
  ///////////////////////////////

  // entry this beat folds into
  assign old_data = line_buf[item.cpos];

  // pooling op against latest entry
  assign pooled = pool_combine(old_data, item.data, pool_type);

  // first beat of a window loads without combining
  assign wr_data = item.first ? item.data : pooled;

  // disabled beats leave the entry alone
  assign wr_en = commit & item.load;

  ///////////////////////////////
  // line buffers
  ///////////////////////////////

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      for (int i = 0; i < BUF_DEPTH; i++) begin
        line_buf[i] <= '0;
      end
    end else if (wr_en) begin
      line_buf[item.cpos] <= wr_data;
    end
  end

  ///////////////////////////////
  // read port
  ///////////////////////////////

  // same-cycle write wins over the stored entry
  always_comb begin
    if (wr_en && (rd_idx == item.cpos)) begin
      rd_data = wr_data;
    end else begin
      rd_data = line_buf[rd_idx];
    end
  end

endmodule

/* rtl/pdp1d_out_seq.sv */
`timescale 1ns/1ns

module pdp1d_out_seq (
  input  logic                          nvdla_core_clk,
  input  logic                          nvdla_core_rstn,
  input  logic                          item_vld,
  input  pdp1d_pkg::pool_item_t         item,
  input  logic                          out_prdy,
  input  logic                          last_out_en,
  input  pdp1d_pkg::lane_vec_t          rd_data,
  input  pdp1d_pkg::lane_vec_t          wr_data,
  output logic                          item_rdy,
  output logic                          commit,
  output logic [pdp1d_pkg::POS_W-1:0]   rd_idx,
  output logic                          out_vld,
  output pdp1d_pkg::pool_out_t          out_pd
);
  import pdp1d_pkg::*;

  logic [POS_W-1:0] out_cnt;
  logic             line_end;
  pool_out_t        flush_q [BUF_DEPTH];
  pool_out_t        live_pd;

  ///////////////////////////////
  // handshake
  ///////////////////////////////

  // output register-free, pipe tail is the output
  assign out_vld  = item_vld;
  assign item_rdy = out_prdy;
  assign commit   = item_vld & out_prdy;

  // line end only counts for a loaded beat
  assign line_end = item.last & item.load;

  ///////////////////////////////
  // output counter
  ///////////////////////////////

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      out_cnt <= '0;
    end else if (commit & (line_end | last_out_en)) begin
      if (out_cnt == POS_W'(BUF_DEPTH - 1)) begin
        out_cnt <= '0;
      end else begin
        out_cnt <= out_cnt + 1'b1;
      end
    end
  end

  // buffer entry presented on output
  assign rd_idx = out_cnt;

  ///////////////////////////////
  // flush latches
  ///////////////////////////////

  // snapshot of the line end for later replay
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      for (int i = 0; i < BUF_DEPTH; i++) begin
        flush_q[i] <= '0;
      end
    end else if (commit & line_end) begin
      flush_q[item.cpos].lc   <= item.lc;
      flush_q[item.cpos].size <= item.size;
      flush_q[item.cpos].data <= wr_data;
    end
  end

  ///////////////////////////////
  // output mux
  ///////////////////////////////

  assign live_pd.lc   = item.lc;
  assign live_pd.size = item.size;
  assign live_pd.data = rd_data;

  // flush replays latches in counter order
  assign out_pd = last_out_en ? flush_q[out_cnt] : live_pd;

endmodule

/* rtl/pdp1d_unit.sv */
`timescale 1ns/1ns

module pdp1d_unit (
  input  logic                  nvdla_core_clk,
  input  logic                  nvdla_core_rstn,
  input  logic                  pdma2pdp_pvld,
  input  pdp1d_pkg::pdp_din_t   pdma2pdp_pd,
  output logic                  pdma2pdp_prdy,
  input  logic                  pooling_din_1st,
  input  logic                  pooling_din_last,
  input  logic                  pdp_din_lc_f,
  input  logic                  cur_datin_disable,
  input  logic                  pooling_unit_en,
  input  logic                  last_out_en,
  input  pdp1d_pkg::pool_type_e pooling_type_cfg,
  output logic                  pooling_out_pvld,
  output pdp1d_pkg::pool_out_t  pooling_out,
  input  logic                  pooling_out_prdy
);
  import pdp1d_pkg::*;

  logic             item_in_vld;
  logic             item_in_rdy;
  pool_item_t       item_in;
  logic             item_out_vld;
  logic             item_out_rdy;
  pool_item_t       item_out;
  logic             commit;
  logic [POS_W-1:0] rd_idx;
  lane_vec_t        rd_data;
  lane_vec_t        wr_data;

  ///////////////////////////////
  // input side
  ///////////////////////////////

  pdp1d_in_stage u_in (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .din_vld         (pdma2pdp_pvld),
    .din             (pdma2pdp_pd),
    .din_1st         (pooling_din_1st),
    .din_last        (pooling_din_last),
    .din_lc          (pdp_din_lc_f),
    .datin_disable   (cur_datin_disable),
    .unit_en         (pooling_unit_en),
    .item_in_rdy     (item_in_rdy),
    .din_rdy         (pdma2pdp_prdy),
    .item_in_vld     (item_in_vld),
    .item_in         (item_in)
  );

  // fixed latency to write-back
  pdp1d_delay_pipe #(
    .payload_t (pool_item_t)
  ) u_pipe (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .in_vld          (item_in_vld),
    .in_pd           (item_in),
    .out_rdy         (item_out_rdy),
    .in_rdy          (item_in_rdy),
    .out_vld         (item_out_vld),
    .out_pd          (item_out)
  );

  ///////////////////////////////
  // write-back and output
  ///////////////////////////////

  pdp1d_accum_buf u_buf (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .pool_type       (pooling_type_cfg),
    .commit          (commit),
    .item            (item_out),
    .rd_idx          (rd_idx),
    .wr_data         (wr_data),
    .rd_data         (rd_data)
  );

  pdp1d_out_seq u_out (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .item_vld        (item_out_vld),
    .item            (item_out),
    .out_prdy        (pooling_out_prdy),
    .last_out_en     (last_out_en),
    .rd_data         (rd_data),
    .wr_data         (wr_data),
    .item_rdy        (item_out_rdy),
    .commit          (commit),
    .rd_idx          (rd_idx),
    .out_vld         (pooling_out_pvld),
    .out_pd          (pooling_out)
  );

endmodule

/* dv/tb_pdp1d.sv */
`timescale 1ns/1ns

module tb_pdp1d;
  import pdp1d_pkg::*;

  // six tests of about 60 beats at up to 8 cycles each plus margin
  localparam int TIMEOUT_CYC = 4000;
  localparam int RST_CYC     = 16;

  logic              nvdla_core_clk;
  logic              nvdla_core_rstn;
  logic              pdma2pdp_pvld;
  pdp_din_t          pdma2pdp_pd;
  logic              pdma2pdp_prdy;
  logic              pooling_din_1st;
  logic              pooling_din_last;
  logic              pdp_din_lc_f;
  logic              cur_datin_disable;
  logic              pooling_unit_en;
  logic              last_out_en;
  pool_type_e        pooling_type_cfg;
  logic              pooling_out_pvld;
  pool_out_t         pooling_out;
  logic              pooling_out_prdy;

  // reference model state
  pool_item_t        in_q [$];
  lane_vec_t         buf_m [BUF_DEPTH];
  pool_out_t         flush_m [BUF_DEPTH];
  logic [POS_W-1:0]  cnt_m;
  logic [SIZE_W-1:0] size_m;
  pool_out_t         exp_out;
  logic              exp_have;

  // run bookkeeping
  int                cycle_cnt;
  int                err_cnt;
  int                out_total;
  int                test_cnt;
  int                bad_tests;
  logic              bp_en;

  pdp1d_unit dut (.*);

  initial nvdla_core_clk = 1'b0;
  always #50 nvdla_core_clk = ~nvdla_core_clk;

  //////////////////////////////
  // timeout and output ready
  //////////////////////////////

  always @(posedge nvdla_core_clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYC) begin
      $display("run stopped after %0d cycles without finishing", TIMEOUT_CYC);
      $display("sim failed");
      $finish;
    end
  end

  // random gaps only while back-pressure test runs
  always @(posedge nvdla_core_clk) begin
    if (bp_en) begin
      pooling_out_prdy <= ($urandom % 3) != 0;
    end else begin
      pooling_out_prdy <= 1'b1;
    end
  end

  //////////////////////////////
  // reference model
  //////////////////////////////

  function automatic lane_vec_t fold_lanes(input lane_vec_t acc, input lane_vec_t din,
                                           input pool_type_e pt);
    lane_vec_t r;
    r = '0;
    for (int i = 0; i < LANES; i++) begin
      if (pt == POOL_MEAN) begin
        r[i] = acc[i] + din[i];
      end else if (pt == POOL_MAX) begin
        r[i] = ($signed(acc[i]) >= $signed(din[i])) ? acc[i] : din[i];
      end else if (pt == POOL_MIN) begin
        r[i] = ($signed(acc[i]) <= $signed(din[i])) ? acc[i] : din[i];
      end
    end
    return r;
  endfunction

  // inputs and outputs are stable at the falling edge
  always @(negedge nvdla_core_clk) begin
    pool_item_t it;
    lane_vec_t  wr;
    lane_vec_t  rd;
    logic       line_end;
    if (!nvdla_core_rstn) begin
      in_q.delete();
      cnt_m    = '0;
      size_m   = '0;
      exp_have = 1'b0;
      for (int i = 0; i < BUF_DEPTH; i++) begin
        buf_m[i]   = '0;
        flush_m[i] = '0;
      end
    end else begin
      // expected output uses state before this commit
      if (pooling_out_pvld && pooling_out_prdy) begin
        out_total = out_total + 1;
        exp_have  = in_q.size() != 0;
        if (exp_have) begin
          it       = in_q.pop_front();
          wr       = it.first ? it.data : fold_lanes(buf_m[it.cpos], it.data, pooling_type_cfg);
          rd       = (it.load && cnt_m == it.cpos) ? wr : buf_m[cnt_m];
          line_end = it.last && it.load;
          if (last_out_en) begin
            exp_out = flush_m[cnt_m];
          end else begin
            exp_out.lc   = it.lc;
            exp_out.size = it.size;
            exp_out.data = rd;
          end
          if (it.load) begin
            buf_m[it.cpos] = wr;
          end
          if (line_end) begin
            flush_m[it.cpos].lc   = it.lc;
            flush_m[it.cpos].size = it.size;
            flush_m[it.cpos].data = wr;
          end
          if (line_end || last_out_en) begin
            cnt_m = cnt_m + 1'b1;
          end
        end
      end
      // accepted input beat carries the count before update
      if (pdma2pdp_pvld && pdma2pdp_prdy) begin
        it.data  = pdma2pdp_pd.data;
        it.cpos  = pdma2pdp_pd.cpos;
        it.first = pooling_din_1st;
        it.last  = pooling_din_last;
        it.lc    = pdp_din_lc_f;
        it.load  = !cur_datin_disable && pooling_unit_en;
        it.size  = size_m;
        in_q.push_back(it);
        if (it.load && it.lc) begin
          size_m = it.last ? '0 : size_m + 1'b1;
        end
      end
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  a_order : assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    pooling_out_pvld && pooling_out_prdy |-> exp_have)
    else begin
      err_cnt = err_cnt + 1;
      $display("output beat taken with no input beat left to match it");
    end

  a_data : assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    pooling_out_pvld && pooling_out_prdy && exp_have |-> pooling_out.data == exp_out.data)
    else begin
      err_cnt = err_cnt + 1;
      $display("MISMATCH pooling_out.data expected %h actual %h",
               $sampled(exp_out.data), $sampled(pooling_out.data));
    end

  a_size : assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    pooling_out_pvld && pooling_out_prdy && exp_have |-> pooling_out.size == exp_out.size)
    else begin
      err_cnt = err_cnt + 1;
      $display("MISMATCH pooling_out.size expected %h actual %h",
               $sampled(exp_out.size), $sampled(pooling_out.size));
    end

  a_lc : assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    pooling_out_pvld && pooling_out_prdy && exp_have |-> pooling_out.lc == exp_out.lc)
    else begin
      err_cnt = err_cnt + 1;
      $display("MISMATCH pooling_out.lc expected %h actual %h",
               $sampled(exp_out.lc), $sampled(pooling_out.lc));
    end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  // holds the beat until the DUT takes it
  task automatic send_beat(input logic [POS_W-1:0] cpos, input logic first, input logic last,
                           input logic lc, input logic dis, input logic en);
    pdp_din_t d;
    logic     taken;
    d.cpos = cpos;
    for (int i = 0; i < LANES; i++) begin
      d.data[i] = lane_t'($urandom);
    end
    pdma2pdp_pvld     <= 1'b1;
    pdma2pdp_pd       <= d;
    pooling_din_1st   <= first;
    pooling_din_last  <= last;
    pdp_din_lc_f      <= lc;
    cur_datin_disable <= dis;
    pooling_unit_en   <= en;
    // ready seen at the falling edge means taken at the next rising edge
    taken = 1'b0;
    while (!taken) begin
      @(negedge nvdla_core_clk);
      taken = pdma2pdp_prdy;
      @(posedge nvdla_core_clk);
    end
  endtask

  // rows of npos beats with the line end on the last position
  task automatic run_windows(input int nwin, input int npos, input int minrows,
                             input int maxrows, input logic gate);
    int   rows;
    logic dis;
    logic en;
    for (int w = 0; w < nwin; w++) begin
      rows = minrows + ($urandom % (maxrows - minrows + 1));
      for (int r = 0; r < rows; r++) begin
        for (int p = 0; p < npos; p++) begin
          dis = gate && ($urandom % 4 == 0);
          en  = !gate || ($urandom % 5 != 0);
          send_beat(POS_W'(p), r == 0, r == rows - 1, p == npos - 1, dis, en);
        end
      end
    end
    pdma2pdp_pvld <= 1'b0;
  endtask

  task automatic drain();
    while (in_q.size() != 0 || pooling_out_pvld) begin
      @(posedge nvdla_core_clk);
    end
    @(posedge nvdla_core_clk);
  endtask

  task automatic close_test(input string name, input int err0, input int out0);
    int errs;
    errs     = err_cnt - err0;
    test_cnt = test_cnt + 1;
    if (errs != 0) begin
      bad_tests = bad_tests + 1;
    end
    $display("test %0d %s: %0d outputs checked, %0d errors", test_cnt, name,
             out_total - out0, errs);
  endtask

  initial begin
    int e0;
    int o0;
    void'($urandom(33));
    cycle_cnt         = 0;
    err_cnt           = 0;
    out_total         = 0;
    test_cnt          = 0;
    bad_tests         = 0;
    bp_en             = 1'b0;
    nvdla_core_rstn   = 1'b0;
    pdma2pdp_pvld     = 1'b0;
    pdma2pdp_pd       = '0;
    pooling_din_1st   = 1'b0;
    pooling_din_last  = 1'b0;
    pdp_din_lc_f      = 1'b0;
    cur_datin_disable = 1'b0;
    pooling_unit_en   = 1'b1;
    last_out_en       = 1'b0;
    pooling_type_cfg  = POOL_MAX;
    pooling_out_prdy  = 1'b1;
    repeat (RST_CYC) @(posedge nvdla_core_clk);
    nvdla_core_rstn <= 1'b1;
    @(posedge nvdla_core_clk);
    if (!pdma2pdp_prdy || pooling_out_pvld) begin
      err_cnt = err_cnt + 1;
      $display("handshake outputs not in their reset state after reset");
    end

    e0 = err_cnt;
    o0 = out_total;
    run_windows(3, 8, 1, 3, 1'b0);
    drain();
    close_test("max pooling", e0, o0);

    pooling_type_cfg <= POOL_MIN;
    e0 = err_cnt;
    o0 = out_total;
    run_windows(3, 8, 1, 3, 1'b0);
    drain();
    close_test("min pooling", e0, o0);

    pooling_type_cfg <= POOL_MEAN;
    e0 = err_cnt;
    o0 = out_total;
    run_windows(3, 8, 1, 3, 1'b0);
    drain();
    close_test("mean pooling", e0, o0);

    // tall windows so the size count wraps
    e0 = err_cnt;
    o0 = out_total;
    run_windows(4, 2, 9, 10, 1'b0);
    drain();
    close_test("size and line end", e0, o0);

    pooling_type_cfg <= POOL_MAX;
    e0 = err_cnt;
    o0 = out_total;
    run_windows(3, 8, 1, 3, 1'b1);
    drain();
    close_test("gating", e0, o0);

    pooling_type_cfg <= POOL_MEAN;
    bp_en <= 1'b1;
    e0 = err_cnt;
    o0 = out_total;
    run_windows(3, 8, 1, 3, 1'b0);
    drain();
    // replay all eight latches with beats that carry no load
    last_out_en <= 1'b1;
    for (int p = 0; p < BUF_DEPTH; p++) begin
      send_beat(POS_W'(p), 1'b0, 1'b0, 1'b0, 1'b1, 1'b1);
    end
    pdma2pdp_pvld <= 1'b0;
    drain();
    last_out_en <= 1'b0;
    bp_en       <= 1'b0;
    close_test("back-pressure and flush", e0, o0);

    $display("tests run %0d, tests with errors %0d, outputs checked %0d, errors %0d",
             test_cnt, bad_tests, out_total, err_cnt);
    if (err_cnt == 0 && bad_tests == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* flist.f */
rtl/pdp1d_pkg.sv
rtl/pdp1d_in_stage.sv
rtl/pdp1d_delay_pipe.sv
rtl/pdp1d_accum_buf.sv
rtl/pdp1d_out_seq.sv
rtl/pdp1d_unit.sv
dv/tb_pdp1d.sv

/* run.sh */
#!/bin/sh
# build and run the pdp1d testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f flist.f \
  --top-module tb_pdp1d \
  -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build did not complete"
  exit 1
fi

out=$(./obj_dir/Vtb_pdp1d)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the verdict is the pass line in the output
if echo "$out" | grep -qx "sim passed"; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1
